//--- src/cpuPkg.sv
package cpuPkg;

    localparam int regWidth = 5;
    localparam logic [regWidth-1:0] raReg = 5'd31;  // Link register written by jal
    localparam logic [2:0] tuseNever = 3'd5;        // Operand is not read at all

    typedef enum logic [5:0] {
        opSpecial = 6'h00,
        opJ       = 6'h02,
        opJal     = 6'h03,
        opBeq     = 6'h04,
        opBgtz    = 6'h07,
        opOri     = 6'h0d,
        opLui     = 6'h0f,
        opLb      = 6'h20,
        opLw      = 6'h23,
        opSh      = 6'h29,
        opSw      = 6'h2b
    } opcodeE;

    // Function field that only means something when the opcode is opSpecial
    typedef enum logic [5:0] {
        fnSll  = 6'h00,
        fnJr   = 6'h08,
        fnJalr = 6'h09,
        fnAddu = 6'h21,
        fnSubu = 6'h23,
        fnSlt  = 6'h2a
    } functE;

    typedef enum logic [4:0] {
        aluNone      = 5'd0,
        aluAdd       = 5'd1,
        aluSub       = 5'd2,
        aluShiftLeft = 5'd3,
        aluLessThan  = 5'd4,
        aluOrOp      = 5'd5,
        aluLoadUpper = 5'd6
    } aluOpE;

    typedef enum logic [3:0] {
        cmpNone            = 4'd0,
        cmpEqual           = 4'd1,
        cmpGreaterThanZero = 4'd2
    } cmpOpE;

    typedef enum logic [2:0] {
        npcSequential = 3'd0,
        npcBranch     = 3'd1,
        npcJump       = 3'd2,
        npcRegister   = 3'd3
    } npcOpE;

    // Where an operand comes from in Decode
    typedef enum logic [1:0] {
        fwdRegFile       = 2'd0,
        fwdFromExecute   = 2'd1,
        fwdFromMemory    = 2'd2,
        fwdFromWriteback = 2'd3
    } fwdSelE;

endpackage

//--- src/instrDecoder.sv
`timescale 1ns/100ps

module instrDecoder (
    input  logic [31:0]                   instr,
    output logic                          rfWe,
    output logic                          dmWe,
    output logic [1:0]                    wdSel,
    output logic                          extOp,
    output logic                          aSel,
    output logic                          bSel,
    output logic [1:0]                    dmType,
    output cpuPkg::aluOpE                 aluOp,
    output cpuPkg::cmpOpE                 cmpOp,
    output cpuPkg::npcOpE                 npcOp,
    output logic [cpuPkg::regWidth-1:0]   rs,
    output logic [cpuPkg::regWidth-1:0]   rt,
    output logic [cpuPkg::regWidth-1:0]   destReg,
    output logic [2:0]                    tuseRs,
    output logic [2:0]                    tuseRt,
    output logic [2:0]                    tnew
);

    import cpuPkg::*;

    opcodeE opcode;
    functE funct;
    logic [regWidth-1:0] rd;
    logic [regWidth-1:0] writeReg;

    assign opcode = opcodeE'(instr[31:26]);
    assign funct = functE'(instr[5:0]);
    assign rs = instr[25:21];
    assign rt = instr[20:16];
    assign rd = instr[15:11];

    assign destReg = rfWe ? writeReg : '0;  // No write means no producer

    always_comb begin
        rfWe = 1'b0;  // Defaults are the nop values
        dmWe = 1'b0;
        wdSel = 2'd0;
        extOp = 1'b0;
        aSel = 1'b0;
        bSel = 1'b0;
        dmType = 2'd0;
        aluOp = aluNone;
        cmpOp = cmpNone;
        npcOp = npcSequential;
        writeReg = rt;
        tnew = 3'd0;
        tuseRs = tuseNever;
        tuseRt = tuseNever;

        if (instr != '0) begin  // All-zero word stays a nop even though it looks like sll
            unique case (opcode)
                opSpecial: begin
                    unique case (funct)
                        fnAddu, fnSubu, fnSlt: begin
                            rfWe = 1'b1;
                            writeReg = rd;
                            tnew = 3'd2;
                            tuseRs = 3'd1;
                            tuseRt = 3'd1;
                            if (funct == fnAddu) aluOp = aluAdd;
                            else if (funct == fnSubu) aluOp = aluSub;
                            else aluOp = aluLessThan;
                        end
                        fnSll: begin
                            rfWe = 1'b1;
                            writeReg = rd;
                            aSel = 1'b1;  // Shift amount replaces rs
                            aluOp = aluShiftLeft;
                            tnew = 3'd2;
                            tuseRt = 3'd1;
                        end
                        fnJr: begin
                            npcOp = npcRegister;
                            tuseRs = 3'd0;
                        end
                        fnJalr: begin
                            npcOp = npcRegister;
                            rfWe = 1'b1;
                            writeReg = rd;
                            wdSel = 2'd2;
                            tnew = 3'd2;
                            tuseRs = 3'd0;
                        end
                        default: ;
                    endcase
                end
                opOri, opLui: begin
                    rfWe = 1'b1;
                    bSel = 1'b1;
                    aluOp = (opcode == opOri) ? aluOrOp : aluLoadUpper;
                    tnew = 3'd2;
                    tuseRs = 3'd1;
                end
                opLw, opLb: begin
                    rfWe = 1'b1;
                    wdSel = 2'd1;  // Write data from memory
                    extOp = 1'b1;
                    bSel = 1'b1;
                    aluOp = aluAdd;
                    dmType = (opcode == opLb) ? 2'd2 : 2'd0;
                    tnew = 3'd3;
                    tuseRs = 3'd1;
                end
                opSw, opSh: begin
                    dmWe = 1'b1;
                    extOp = 1'b1;
                    bSel = 1'b1;
                    aluOp = aluAdd;
                    dmType = (opcode == opSh) ? 2'd1 : 2'd0;
                    tuseRs = 3'd1;
                    tuseRt = 3'd2;  // Store data is needed only in Memory
                end
                opBeq, opBgtz: begin
                    npcOp = npcBranch;
                    extOp = 1'b1;
                    cmpOp = (opcode == opBeq) ? cmpEqual : cmpGreaterThanZero;
                    tuseRs = 3'd0;
                    tuseRt = 3'd0;
                end
                opJ: begin
                    npcOp = npcJump;
                end
                opJal: begin
                    npcOp = npcJump;
                    rfWe = 1'b1;
                    writeReg = raReg;
                    wdSel = 2'd2;  // Link address
                    tnew = 3'd2;
                end
                default: ;
            endcase
        end
    end

endmodule

//--- src/pipeTracker.sv
`timescale 1ns/100ps

module pipeTracker (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          stall,
    input  logic [cpuPkg::regWidth-1:0]   destReg,
    input  logic [2:0]                    tnew,
    output logic [cpuPkg::regWidth-1:0]   destE,
    output logic [cpuPkg::regWidth-1:0]   destM,
    output logic [cpuPkg::regWidth-1:0]   destW,
    output logic [2:0]                    tnewE,
    output logic [2:0]                    tnewM,
    output logic [2:0]                    tnewW
);

    import cpuPkg::*;

    logic [regWidth-1:0] nextDestE;
    logic [2:0] nextTnewE;

    // Each stage takes one cycle off the result time and stops at zero
    function automatic logic [2:0] countDown(input logic [2:0] t);
        return (t == 3'd0) ? 3'd0 : t - 3'd1;
    endfunction

    always_comb begin
        if (stall) begin
            nextDestE = '0;  // Bubble while Decode holds its instruction
            nextTnewE = 3'd0;
        end else begin
            nextDestE = destReg;
            nextTnewE = countDown(tnew);
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            destE <= '0;
            destM <= '0;
            destW <= '0;
            tnewE <= 3'd0;
            tnewM <= 3'd0;
            tnewW <= 3'd0;
        end else begin
            destE <= nextDestE;
            tnewE <= nextTnewE;
            destM <= destE;
            tnewM <= countDown(tnewE);
            destW <= destM;
            tnewW <= countDown(tnewM);
        end
    end

endmodule

//--- src/hazardUnit.sv
`timescale 1ns/100ps

module hazardUnit (
    input  logic [cpuPkg::regWidth-1:0]   rs,
    input  logic [cpuPkg::regWidth-1:0]   rt,
    input  logic [2:0]                    tuseRs,
    input  logic [2:0]                    tuseRt,
    input  logic [cpuPkg::regWidth-1:0]   destE,
    input  logic [cpuPkg::regWidth-1:0]   destM,
    input  logic [cpuPkg::regWidth-1:0]   destW,
    input  logic [2:0]                    tnewE,
    input  logic [2:0]                    tnewM,
    input  logic [2:0]                    tnewW,
    output logic                          stall,
    output cpuPkg::fwdSelE                fwdRs,
    output cpuPkg::fwdSelE                fwdRt
);

    import cpuPkg::*;

    logic stallRs;
    logic stallRt;
    fwdSelE selRs;
    fwdSelE selRt;

    // Nearest older writer wins, so Execute is searched before Memory and Writeback
    function automatic void checkSource(
        input  logic [regWidth-1:0] src,
        input  logic [2:0]          tuse,
        output logic                needStall,
        output fwdSelE              sel
    );
        logic [2:0] ready;
        needStall = 1'b0;
        sel = fwdRegFile;
        ready = 3'd0;
        if (tuse != tuseNever && src != '0) begin
            if (destE == src) begin
                sel = fwdFromExecute;
                ready = tnewE;
            end else if (destM == src) begin
                sel = fwdFromMemory;
                ready = tnewM;
            end else if (destW == src) begin
                sel = fwdFromWriteback;
                ready = tnewW;
            end
            needStall = (sel != fwdRegFile) && (ready > tuse);
        end
    endfunction

    always_comb begin
        checkSource(rs, tuseRs, stallRs, selRs);
        checkSource(rt, tuseRt, stallRt, selRt);
        stall = stallRs | stallRt;
        fwdRs = stall ? fwdRegFile : selRs;  // A stalled instruction reads nothing yet
        fwdRt = stall ? fwdRegFile : selRt;
    end

endmodule

//--- src/decodeStage.sv
`timescale 1ns/100ps

module decodeStage (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic [31:0]                   instr,
    output logic                          rfWe,
    output logic                          dmWe,
    output logic [1:0]                    wdSel,
    output logic                          extOp,
    output logic                          aSel,
    output logic                          bSel,
    output logic [1:0]                    dmType,
    output cpuPkg::aluOpE                 aluOp,
    output cpuPkg::cmpOpE                 cmpOp,
    output cpuPkg::npcOpE                 npcOp,
    output logic [cpuPkg::regWidth-1:0]   rs,
    output logic [cpuPkg::regWidth-1:0]   rt,
    output logic [cpuPkg::regWidth-1:0]   destReg,
    output logic [2:0]                    tuseRs,
    output logic [2:0]                    tuseRt,
    output logic [2:0]                    tnew,
    output logic                          stall,
    output cpuPkg::fwdSelE                fwdRs,
    output cpuPkg::fwdSelE                fwdRt
);

    import cpuPkg::*;

    logic [regWidth-1:0] destE;
    logic [regWidth-1:0] destM;
    logic [regWidth-1:0] destW;
    logic [2:0] tnewE;
    logic [2:0] tnewM;
    logic [2:0] tnewW;

    instrDecoder decoder (
        .instr(instr),
        .rfWe(rfWe),
        .dmWe(dmWe),
        .wdSel(wdSel),
        .extOp(extOp),
        .aSel(aSel),
        .bSel(bSel),
        .dmType(dmType),
        .aluOp(aluOp),
        .cmpOp(cmpOp),
        .npcOp(npcOp),
        .rs(rs),
        .rt(rt),
        .destReg(destReg),
        .tuseRs(tuseRs),
        .tuseRt(tuseRt),
        .tnew(tnew)
    );

    pipeTracker tracker (
        .clk(clk),
        .rstN(rstN),
        .stall(stall),
        .destReg(destReg),
        .tnew(tnew),
        .destE(destE),
        .destM(destM),
        .destW(destW),
        .tnewE(tnewE),
        .tnewM(tnewM),
        .tnewW(tnewW)
    );

    hazardUnit hazard (
        .rs(rs),
        .rt(rt),
        .tuseRs(tuseRs),
        .tuseRt(tuseRt),
        .destE(destE),
        .destM(destM),
        .destW(destW),
        .tnewE(tnewE),
        .tnewM(tnewM),
        .tnewW(tnewW),
        .stall(stall),
        .fwdRs(fwdRs),
        .fwdRt(fwdRt)
    );

endmodule

//--- sim/decodeStage_assertions.sv
`timescale 1ns/100ps

module decodeStage_assertions (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          stall,
    input  cpuPkg::fwdSelE                fwdRs,
    input  cpuPkg::fwdSelE                fwdRt,
    input  logic [cpuPkg::regWidth-1:0]   destE
);

    import cpuPkg::*;

    stallNoForward: assert property (@(posedge clk) disable iff (!rstN)
        stall |-> (fwdRs == fwdRegFile && fwdRt == fwdRegFile))
        else $error("Forward select active while stalled");

    // A bubble in Execute holds no result to forward
    executeHasProducer: assert property (@(posedge clk) disable iff (!rstN)
        (fwdRs == fwdFromExecute || fwdRt == fwdFromExecute) |-> destE != '0)
        else $error("Forward from Execute with no producer there");

    noStallAfterReset: assert property (@(posedge clk) $rose(rstN) |-> !stall)
        else $error("Stall high in the first cycle after reset");

endmodule

bind decodeStage decodeStage_assertions assertChecks (
    .clk(clk),
    .rstN(rstN),
    .stall(stall),
    .fwdRs(fwdRs),
    .fwdRt(fwdRt),
    .destE(destE)
);

//--- sim/decodeStageTb.sv
`timescale 1ns/100ps

module decodeStageTb;

    import cpuPkg::*;

    typedef struct packed {
        logic rfWe, dmWe, extOp, aSel, bSel;
        logic [1:0] wdSel, dmType;
        aluOpE aluOp;
        cmpOpE cmpOp;
        npcOpE npcOp;
        logic [4:0] destReg;
        logic [2:0] tuseRs, tuseRt, tnew;
    } ctrlT;

    logic clk, rstN, stall, rfWe, dmWe, extOp, aSel, bSel;
    logic [31:0] instr;
    logic [1:0] wdSel, dmType;
    aluOpE aluOp;
    cmpOpE cmpOp;
    npcOpE npcOp;
    logic [4:0] rs, rt, destReg;
    logic [2:0] tuseRs, tuseRt, tnew;
    fwdSelE fwdRs, fwdRt, expFwdRs, expFwdRt, nextFwdRs, nextFwdRt;
    logic [4:0] modelDest [3];  // Execute, Memory, Writeback
    logic [2:0] modelTnew [3];
    ctrlT expCtrl, nextCtrl;
    logic expStall, nextStall;
    string testName;
    int stallCycles;

    // Supported instructions in order addu subu jr sll slt jalr ori lui lw sw beq j jal sh lb bgtz,
    // then four encodings the decoder does not know
    logic [5:0] opTable [20] = '{6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h0d, 6'h0f, 6'h23,
        6'h2b, 6'h04, 6'h02, 6'h03, 6'h29, 6'h20, 6'h07, 6'h3f, 6'h01, 6'h10, 6'h00};
    logic [5:0] fnTable [20] = '{6'h21, 6'h23, 6'h08, 6'h00, 6'h2a, 6'h09, 6'h00, 6'h00, 6'h00,
        6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h3f};

    decodeStage dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic checkVal(input string what, input logic [31:0] expVal,
                            input logic [31:0] actVal);
        if (actVal !== expVal) begin
            $display("Error in %s, %s: expected %0h, actual %0h", testName, what, expVal, actVal);
            $display("TEST FAIL");
            $fatal(1, "Output mismatch");
        end
    endtask

    function automatic logic [2:0] countDown(input logic [2:0] t);
        return (t == 3'd0) ? 3'd0 : t - 3'd1;
    endfunction

    function automatic logic [31:0] makeInstr(input int kind, input logic [4:0] s,
                                              input logic [4:0] t, input logic [4:0] d);
        return {opTable[kind], s, t, d, 5'd2, fnTable[kind]};
    endfunction

    function automatic ctrlT refDecode(input logic [31:0] w);
        ctrlT c;
        logic [4:0] wr;
        c = '0;
        c.tuseRs = tuseNever;
        c.tuseRt = tuseNever;
        wr = w[20:16];  // I-type instructions write rt
        if (w != 32'h0) begin
            case (w[31:26])
                6'h00: begin
                    wr = w[15:11];
                    case (w[5:0])
                        6'h21, 6'h23, 6'h2a: begin
                            {c.rfWe, c.tnew, c.tuseRs, c.tuseRt} = {1'b1, 3'd2, 3'd1, 3'd1};
                            c.aluOp = (w[5:0] == 6'h21) ? aluAdd
                                    : (w[5:0] == 6'h23) ? aluSub : aluLessThan;
                        end
                        6'h00: begin  // Sll shifts rt by shamt
                            {c.rfWe, c.aSel, c.tnew, c.tuseRt} = {1'b1, 1'b1, 3'd2, 3'd1};
                            c.aluOp = aluShiftLeft;
                        end
                        6'h08: begin
                            c.npcOp = npcRegister;
                            c.tuseRs = 3'd0;
                        end
                        6'h09: begin
                            {c.rfWe, c.wdSel, c.tnew, c.tuseRs} = {1'b1, 2'd2, 3'd2, 3'd0};
                            c.npcOp = npcRegister;
                        end
                        default: ;
                    endcase
                end
                6'h0d, 6'h0f: begin
                    {c.rfWe, c.bSel, c.tnew, c.tuseRs} = {1'b1, 1'b1, 3'd2, 3'd1};
                    c.aluOp = (w[31:26] == 6'h0d) ? aluOrOp : aluLoadUpper;
                end
                6'h23, 6'h20: begin  // Loads are ready only after Memory
                    {c.rfWe, c.wdSel, c.extOp, c.bSel} = {1'b1, 2'd1, 1'b1, 1'b1};
                    {c.tnew, c.tuseRs} = {3'd3, 3'd1};
                    c.dmType = (w[31:26] == 6'h20) ? 2'd2 : 2'd0;
                    c.aluOp = aluAdd;
                end
                6'h2b, 6'h29: begin
                    {c.dmWe, c.extOp, c.bSel} = {1'b1, 1'b1, 1'b1};
                    {c.tuseRs, c.tuseRt} = {3'd1, 3'd2};
                    c.dmType = (w[31:26] == 6'h29) ? 2'd1 : 2'd0;
                    c.aluOp = aluAdd;
                end
                6'h04, 6'h07: begin  // Branches compare in Decode
                    {c.extOp, c.tuseRs, c.tuseRt} = {1'b1, 3'd0, 3'd0};
                    c.npcOp = npcBranch;
                    c.cmpOp = (w[31:26] == 6'h04) ? cmpEqual : cmpGreaterThanZero;
                end
                6'h02: c.npcOp = npcJump;
                6'h03: begin
                    {c.rfWe, c.wdSel, c.tnew} = {1'b1, 2'd2, 3'd2};
                    c.npcOp = npcJump;
                    wr = raReg;
                end
                default: ;
            endcase
        end
        c.destReg = c.rfWe ? wr : 5'd0;
        return c;
    endfunction

    function automatic void refHazard(input logic [31:0] w, input ctrlT c, output logic st,
                                      output fwdSelE fRs, output fwdSelE fRt);
        logic [4:0] src [2];
        logic [2:0] tuse [2];
        fwdSelE sel [2];
        logic hit;
        src = '{w[25:21], w[20:16]};
        tuse = '{c.tuseRs, c.tuseRt};
        st = 1'b0;
        for (int k = 0; k < 2; k++) begin
            sel[k] = fwdRegFile;
            hit = 1'b0;
            for (int i = 0; i < 3; i++) begin
                if (!hit && tuse[k] != tuseNever && src[k] != 5'd0 && modelDest[i] == src[k]) begin
                    hit = 1'b1;  // Nearest stage found
                    sel[k] = (i == 0) ? fwdFromExecute
                           : (i == 1) ? fwdFromMemory : fwdFromWriteback;
                    st = st | (modelTnew[i] > tuse[k]);
                end
            end
        end
        fRs = st ? fwdRegFile : sel[0];
        fRt = st ? fwdRegFile : sel[1];
    endfunction

    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            modelDest <= '{default: 5'd0};
            modelTnew <= '{default: 3'd0};
        end else begin
            nextCtrl = refDecode(instr);
            refHazard(instr, nextCtrl, nextStall, nextFwdRs, nextFwdRt);
            modelDest[0] <= nextStall ? 5'd0 : nextCtrl.destReg;  // Bubble on stall
            modelTnew[0] <= nextStall ? 3'd0 : countDown(nextCtrl.tnew);
            modelDest[1] <= modelDest[0];
            modelTnew[1] <= countDown(modelTnew[0]);
            modelDest[2] <= modelDest[1];
            modelTnew[2] <= countDown(modelTnew[1]);
        end
    end

    always @(negedge clk) begin
        if (rstN) begin
            expCtrl = refDecode(instr);
            refHazard(instr, expCtrl, expStall, expFwdRs, expFwdRt);
            checkVal("rfWe/dmWe", {expCtrl.rfWe, expCtrl.dmWe}, {rfWe, dmWe});
            checkVal("wdSel/dmType", {expCtrl.wdSel, expCtrl.dmType}, {wdSel, dmType});
            checkVal("extOp/aSel/bSel", {expCtrl.extOp, expCtrl.aSel, expCtrl.bSel},
                     {extOp, aSel, bSel});
            checkVal("aluOp", expCtrl.aluOp, aluOp);
            checkVal("cmpOp", expCtrl.cmpOp, cmpOp);
            checkVal("npcOp", expCtrl.npcOp, npcOp);
            checkVal("rs", instr[25:21], rs);
            checkVal("rt", instr[20:16], rt);
            checkVal("destReg", expCtrl.destReg, destReg);
            checkVal("tuseRs/tuseRt/tnew", {expCtrl.tuseRs, expCtrl.tuseRt, expCtrl.tnew},
                     {tuseRs, tuseRt, tnew});
            checkVal("stall", expStall, stall);
            checkVal("fwdRs", expFwdRs, fwdRs);
            checkVal("fwdRt", expFwdRt, fwdRt);
        end
    end

    task automatic issueInstr(input logic [31:0] word);
        @(posedge clk);
        #2;
        instr = word;
        stallCycles = 0;
        @(negedge clk);
        while (stall) begin  // Instruction stays in Decode until the stall clears
            if (stallCycles == 10) begin
                $display("Stall stayed high for 10 cycles on instruction %h", word);
                $display("TEST FAIL");
                $fatal(1, "Stall timeout");
            end
            stallCycles++;
            @(negedge clk);
        end
    endtask

    initial begin
        void'($urandom(32'h6731165d));
        rstN = 1'b0;
        instr = makeInstr(0, 5'd3, 5'd4, 5'd5);  // Addu with nonzero sources held in reset
        testName = "reset";
        repeat (4) @(posedge clk);
        #2;
        rstN = 1'b1;
        @(negedge clk);
        checkVal("stall", 0, stall);
        checkVal("fwdRs", fwdRegFile, fwdRs);
        checkVal("fwdRt", fwdRegFile, fwdRt);

        testName = "decode table";
        for (int k = 0; k < 20; k++) begin
            issueInstr(makeInstr(k, 5'($urandom), 5'($urandom), 5'($urandom)));
        end
        issueInstr(32'h0);

        testName = "load use";
        repeat (3) issueInstr(32'h0);
        issueInstr(makeInstr(8, 5'd1, 5'd5, 5'd0));
        issueInstr(makeInstr(0, 5'd5, 5'd7, 5'd6));
        // Load needs two more cycles in Execute but addu reads after one, so one bubble
        checkVal("stall cycles", 1, stallCycles);
        checkVal("fwdRs", fwdFromMemory, fwdRs);
        checkVal("fwdRt", fwdRegFile, fwdRt);

        testName = "nearest forward";
        issueInstr(makeInstr(6, 5'd0, 5'd8, 5'd0));
        issueInstr(makeInstr(6, 5'd0, 5'd8, 5'd0));
        issueInstr(makeInstr(0, 5'd8, 5'd8, 5'd9));
        checkVal("fwdRs", fwdFromExecute, fwdRs);
        checkVal("fwdRt", fwdFromExecute, fwdRt);
        issueInstr(makeInstr(6, 5'd0, 5'd0, 5'd0));
        issueInstr(makeInstr(8, 5'd0, 5'd0, 5'd0));
        issueInstr(makeInstr(0, 5'd0, 5'd0, 5'd10));
        checkVal("stall cycles", 0, stallCycles);
        checkVal("fwdRs", fwdRegFile, fwdRs);
        checkVal("fwdRt", fwdRegFile, fwdRt);

        testName = "random stream";
        for (int n = 0; n < 500; n++) begin
            issueInstr(makeInstr($urandom_range(19, 0), 5'($urandom_range(3, 0)),
                                 5'($urandom_range(3, 0)), 5'($urandom_range(3, 0))));
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

//--- list.f
src/cpuPkg.sv
src/instrDecoder.sv
src/pipeTracker.sv
src/hazardUnit.sv
src/decodeStage.sv
sim/decodeStage_assertions.sv
sim/decodeStageTb.sv

//--- run.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
logFile=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module decodeStageTb -f list.f -o simDecode
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simDecode > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "^TEST PASS$" "$logFile"; then
    exit 0
fi
echo "Pass message not found in $logFile"
exit 1
